// File: rtl/vxe_pkg.sv
`default_nettype none

package vxe_pkg;

  // number of fraction bits in the signed Q16.16 format
  localparam int FRAC_BITS = 16;

  // stages of the pipe that retimes the wide product
  localparam int MUL_LAT = 2;

  // edges from the input strobe to the output strobe of the whole lane
  localparam int FMA_LAT = 5;

  // signed Q16.16 operand or result
  typedef logic signed [31:0] fix_t;

  // full signed product of two fix_t values
  typedef logic signed [63:0] prod_t;

  // shifted product plus sign-extended addend, wide enough never to wrap
  typedef logic signed [48:0] wide_t;

  // tag that travels with an operation unchanged
  typedef logic [3:0] tag_t;

  // limits of the representable range, used for saturation
  localparam fix_t FIX_MAX = {1'b0, {31{1'b1}}};
  localparam fix_t FIX_MIN = {1'b1, {31{1'b0}}};

endpackage

`default_nettype wire

// File: rtl/vxe_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module vxe_pipe #(
  parameter int DATA_WIDTH = 32,
  parameter int NSTAGES    = 1
) (
  input  wire logic                  clk,
  input  wire logic                  nrst,
  output      logic                  o_busy,
  input  wire logic [DATA_WIDTH-1:0] i_data,
  input  wire logic                  i_vld,
  output      logic [DATA_WIDTH-1:0] o_data,
  output      logic                  o_vld
);

  // stage 0 is the output end, new words enter at NSTAGES-1
  logic [DATA_WIDTH-1:0] stages [NSTAGES];
  logic [NSTAGES-1:0]    vld;
  logic                  pipe_en;
  logic                  shift;
  logic                  en_next;

  // the pipe moves only while something is inside or a new word arrives
  assign shift = pipe_en | i_vld;

  // stay enabled while any valid word has still to reach the output stage
  always_comb
  begin
    en_next = i_vld;
    for (int s = 1; s < NSTAGES; s++)
    begin
      en_next = en_next | vld[s];
    end
  end

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      vld     <= '0;
      pipe_en <= 1'b0;
    end
    else if (shift)
    begin
      vld[NSTAGES-1] <= i_vld;
      for (int s = 1; s < NSTAGES; s++)
      begin
        vld[s-1] <= vld[s];
      end
      pipe_en <= en_next;
    end
  end

  // data words follow the valid bits but hold their value once drained
  always_ff @(posedge clk)
  begin
    if (shift)
    begin
      stages[NSTAGES-1] <= i_data;
      for (int s = 1; s < NSTAGES; s++)
      begin
        stages[s-1] <= stages[s];
      end
    end
  end

  assign o_data = stages[0];
  assign o_vld  = vld[0];
  assign o_busy = pipe_en;

endmodule

`default_nettype wire

// File: rtl/vxe_mul_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module vxe_mul_pipe (
  input  wire logic          clk,
  input  wire logic          nrst,
  input  wire logic          i_vld,
  input  wire vxe_pkg::fix_t i_a,
  input  wire vxe_pkg::fix_t i_x,
  output      logic          o_vld,
  output vxe_pkg::prod_t     o_prod,
  output      logic          o_busy
);

  vxe_pkg::fix_t  a_q;
  vxe_pkg::fix_t  x_q;
  logic           in_vld;
  vxe_pkg::prod_t prod;
  logic           pipe_busy;

  // the valid bit of the input register is control state and is reset
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      in_vld <= 1'b0;
    end
    else
    begin
      in_vld <= i_vld;
    end
  end

  // operands are captured only for an accepted operation
  always_ff @(posedge clk)
  begin
    if (i_vld)
    begin
      a_q <= i_a;
      x_q <= i_x;
    end
  end

  // both operands are signed, so the 64-bit product is exact
  assign prod = vxe_pkg::prod_t'(a_q) * vxe_pkg::prod_t'(x_q);

  // the registers after the multiplier give synthesis room to retime it
  vxe_pipe #(
    .DATA_WIDTH ($bits(vxe_pkg::prod_t)),
    .NSTAGES    (vxe_pkg::MUL_LAT)
  ) u_prod_pipe (
    .clk    (clk),
    .nrst   (nrst),
    .o_busy (pipe_busy),
    .i_data (prod),
    .i_vld  (in_vld),
    .o_data (o_prod),
    .o_vld  (o_vld)
  );

  // an operation sitting in the input register is in flight as well
  assign o_busy = in_vld | pipe_busy;

endmodule

`default_nettype wire

// File: rtl/vxe_res_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vxe_res_if;

  // one-cycle strobe that marks a valid sum
  logic           vld;
  // sum before saturation, with the product already shifted to Q16.16
  vxe_pkg::wide_t sum;
  vxe_pkg::tag_t  tag;
  // high while anything is still inside the datapath
  logic           busy;

  // the datapath drives all four signals
  modport src (
    output vld,
    output sum,
    output tag,
    output busy
  );

  // the saturation stage only reads them
  modport dst (
    input vld,
    input sum,
    input tag,
    input busy
  );

endinterface

`default_nettype wire

// File: rtl/vxe_fma_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module vxe_fma_datapath (
  input  wire logic          clk,
  input  wire logic          nrst,
  input  wire logic          i_vld,
  input  wire vxe_pkg::fix_t i_a,
  input  wire vxe_pkg::fix_t i_x,
  input  wire vxe_pkg::fix_t i_b,
  input  wire vxe_pkg::tag_t i_tag,
  vxe_res_if.src             res
);

  localparam int ADD_W = $bits(vxe_pkg::tag_t) + $bits(vxe_pkg::fix_t);

  logic             mul_vld;
  vxe_pkg::prod_t   mul_prod;
  logic             mul_busy;
  logic [ADD_W-1:0] add_data;
  logic             add_vld;
  logic             add_busy;
  vxe_pkg::fix_t    add_b;
  vxe_pkg::tag_t    add_tag;
  vxe_pkg::prod_t   prod_sh;
  vxe_pkg::wide_t   sum_d;
  vxe_pkg::wide_t   sum_q;
  vxe_pkg::tag_t    tag_q;
  logic             sum_vld;

  vxe_mul_pipe u_mul (
    .clk    (clk),
    .nrst   (nrst),
    .i_vld  (i_vld),
    .i_a    (i_a),
    .i_x    (i_x),
    .o_vld  (mul_vld),
    .o_prod (mul_prod),
    .o_busy (mul_busy)
  );

  // three stages match the input register plus the two product stages
  vxe_pipe #(
    .DATA_WIDTH (ADD_W),
    .NSTAGES    (3)
  ) u_add_pipe (
    .clk    (clk),
    .nrst   (nrst),
    .o_busy (add_busy),
    .i_data ({i_tag, i_b}),
    .i_vld  (i_vld),
    .o_data (add_data),
    .o_vld  (add_vld)
  );

  assign add_tag = add_data[ADD_W-1 -: $bits(vxe_pkg::tag_t)];
  assign add_b   = add_data[$bits(vxe_pkg::fix_t)-1:0];

  // truncate toward minus infinity by an arithmetic shift of the signed product
  assign prod_sh = mul_prod >>> vxe_pkg::FRAC_BITS;

  // the shifted product has 48 significant bits, so the low 49 keep its sign
  assign sum_d = vxe_pkg::wide_t'(prod_sh) + vxe_pkg::wide_t'(add_b);

  // both pipes carry the same strobe, so their outputs always coincide
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      sum_vld <= 1'b0;
    end
    else
    begin
      sum_vld <= mul_vld & add_vld;
    end
  end

  always_ff @(posedge clk)
  begin
    if (mul_vld)
    begin
      sum_q <= sum_d;
      tag_q <= add_tag;
    end
  end

  assign res.vld  = sum_vld;
  assign res.sum  = sum_q;
  assign res.tag  = tag_q;
  assign res.busy = mul_busy | add_busy | sum_vld;

endmodule

`default_nettype wire

// File: rtl/vxe_result_sat.sv
`timescale 1ns/1ps
`default_nettype none

module vxe_result_sat (
  input  wire logic      clk,
  input  wire logic      nrst,
  vxe_res_if.dst         res,
  output      logic      o_vld,
  output vxe_pkg::fix_t  o_res,
  output      logic      o_ovf,
  output vxe_pkg::tag_t  o_tag,
  output      logic      o_busy
);

  logic          over_hi;
  logic          over_lo;
  vxe_pkg::fix_t sat_res;

  // compare in the wide domain, the casts sign-extend the limits
  assign over_hi = res.sum > vxe_pkg::wide_t'(vxe_pkg::FIX_MAX);
  assign over_lo = res.sum < vxe_pkg::wide_t'(vxe_pkg::FIX_MIN);

  // a value exactly at a limit passes through and is not flagged
  always_comb
  begin
    if (over_hi)
    begin
      sat_res = vxe_pkg::FIX_MAX;
    end
    else if (over_lo)
    begin
      sat_res = vxe_pkg::FIX_MIN;
    end
    else
    begin
      sat_res = vxe_pkg::fix_t'(res.sum);
    end
  end

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      o_vld <= 1'b0;
    end
    else
    begin
      o_vld <= res.vld;
    end
  end

  // result fields only change when a new sum arrives
  always_ff @(posedge clk)
  begin
    if (res.vld)
    begin
      o_res <= sat_res;
      o_ovf <= over_hi | over_lo;
      o_tag <= res.tag;
    end
  end

  // the lane is busy until the result strobe itself has gone
  assign o_busy = res.busy | o_vld;

endmodule

`default_nettype wire

// File: rtl/vxe_fma_top.sv
`timescale 1ns/1ps
`default_nettype none

module vxe_fma_top (
  input  wire logic          clk,
  input  wire logic          nrst,
  input  wire logic          i_vld,
  input  wire vxe_pkg::fix_t i_a,
  input  wire vxe_pkg::fix_t i_x,
  input  wire vxe_pkg::fix_t i_b,
  input  wire vxe_pkg::tag_t i_tag,
  output      logic          o_vld,
  output vxe_pkg::fix_t      o_res,
  output      logic          o_ovf,
  output vxe_pkg::tag_t      o_tag,
  output      logic          o_busy
);

  // unsaturated sum handed from the datapath to the saturation stage
  vxe_res_if res_if ();

  // multiply, align and add, four edges deep
  vxe_fma_datapath u_datapath (
    .clk   (clk),
    .nrst  (nrst),
    .i_vld (i_vld),
    .i_a   (i_a),
    .i_x   (i_x),
    .i_b   (i_b),
    .i_tag (i_tag),
    .res   (res_if.src)
  );

  // the fifth edge clamps and registers the lane outputs
  vxe_result_sat u_sat (
    .clk    (clk),
    .nrst   (nrst),
    .res    (res_if.dst),
    .o_vld  (o_vld),
    .o_res  (o_res),
    .o_ovf  (o_ovf),
    .o_tag  (o_tag),
    .o_busy (o_busy)
  );

endmodule

`default_nettype wire

// File: sim/vxe_fma_props.sv
`timescale 1ns/1ps
`default_nettype none

module vxe_fma_props (
  input wire logic clk,
  input wire logic nrst,
  input wire logic i_vld,
  input wire logic o_vld,
  input wire logic o_busy
);

  localparam int LAT = vxe_pkg::FMA_LAT;

  // failures seen so far, read by the testbench at the end of the run
  int fail_cnt = 0;

  // an accepted operation always leaves the lane exactly LAT edges later
  lat_fwd: assert property (@(posedge clk) disable iff (!nrst)
    i_vld |-> ##LAT o_vld)
  else
  begin
    $error("result strobe missing after the fixed latency");
    fail_cnt++;
  end

  // and no strobe appears without an operation LAT edges before it
  lat_back: assert property (@(posedge clk) disable iff (!nrst)
    o_vld |-> $past(i_vld, LAT))
  else
  begin
    $error("result strobe without a matching input strobe");
    fail_cnt++;
  end

  // the lane is quiet while in reset and on the first edge after release
  rst_idle: assert property (@(posedge clk)
    (!nrst || $rose(nrst)) |-> (!o_busy && !o_vld))
  else
  begin
    $error("busy or result strobe set during or right after reset");
    fail_cnt++;
  end

  // busy is seen from the first edge after acceptance through the result cycle
  busy_pending: assert property (@(posedge clk) disable iff (!nrst)
    i_vld |=> o_busy [*LAT])
  else
  begin
    $error("busy dropped while an operation was in flight");
    fail_cnt++;
  end

endmodule

bind vxe_fma_top vxe_fma_props props0 (
  .clk    (clk),
  .nrst   (nrst),
  .i_vld  (i_vld),
  .o_vld  (o_vld),
  .o_busy (o_busy)
);

`default_nettype wire

// File: sim/vxe_fma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vxe_fma_tb;

  // the tests need roughly 1400 cycles, so this leaves about twice that
  localparam int MAX_CYCLES = 3000;

  logic          clk;
  logic          nrst;
  logic          i_vld;
  vxe_pkg::fix_t i_a;
  vxe_pkg::fix_t i_x;
  vxe_pkg::fix_t i_b;
  vxe_pkg::tag_t i_tag;
  logic          o_vld;
  vxe_pkg::fix_t o_res;
  logic          o_ovf;
  vxe_pkg::tag_t o_tag;
  logic          o_busy;

  // expected outputs packed as {ovf, tag, res}, oldest first
  logic [36:0]   exp_q [$];
  logic          head_ok;
  logic          head_ovf;
  vxe_pkg::tag_t head_tag;
  vxe_pkg::fix_t head_res;
  int            err_cnt = 0;
  int            n_tests = 0;
  int            cycles = 0;

  vxe_fma_top dut0 (
    .clk    (clk),
    .nrst   (nrst),
    .i_vld  (i_vld),
    .i_a    (i_a),
    .i_x    (i_x),
    .i_b    (i_b),
    .i_tag  (i_tag),
    .o_vld  (o_vld),
    .o_res  (o_res),
    .o_ovf  (o_ovf),
    .o_tag  (o_tag),
    .o_busy (o_busy)
  );

  always #2 clk = ~clk;

  // a*x+b in Q16.16, product truncated toward minus infinity, then clamped
  function automatic logic [36:0] expect_op(input vxe_pkg::fix_t a, input vxe_pkg::fix_t x,
                                            input vxe_pkg::fix_t b, input vxe_pkg::tag_t tag);
    longint      prod;
    longint      sum;
    logic        ovf;
    logic [31:0] res;
    prod = longint'(a) * longint'(x);
    sum  = (prod >>> vxe_pkg::FRAC_BITS) + longint'(b);
    ovf  = 1'b1;
    if (sum > 64'sd2147483647)
    begin
      res = 32'h7fff_ffff;
    end
    else if (sum < -64'sd2147483648)
    begin
      res = 32'h8000_0000;
    end
    else
    begin
      res = sum[31:0];
      ovf = 1'b0;
    end
    return {ovf, tag, res};
  endfunction

  // the scoreboard sees the same pre-edge values as the DUT registers do
  always @(posedge clk)
  begin
    if (!nrst)
    begin
      exp_q.delete();
    end
    else
    begin
      if (o_vld && exp_q.size() > 0)
      begin
        void'(exp_q.pop_front());
      end
      if (i_vld)
      begin
        exp_q.push_back(expect_op(i_a, i_x, i_b, i_tag));
      end
    end
    head_ok <= exp_q.size() > 0;
    if (exp_q.size() > 0)
    begin
      {head_ovf, head_tag, head_res} <= exp_q[0];
    end
  end

  // every result strobe must find an operation waiting
  strobe_expected: assert property (@(posedge clk) disable iff (!nrst)
    o_vld |-> head_ok)
  else
  begin
    $display("%0t: result strobe arrived with no operation pending", $time);
    err_cnt++;
  end

  res_check: assert property (@(posedge clk) disable iff (!nrst)
    (o_vld && head_ok) |-> (o_res == head_res))
  else
  begin
    $display("MISMATCH %0t: result %h, expected %h", $time, $sampled(o_res),
             $sampled(head_res));
    err_cnt++;
  end

  ovf_check: assert property (@(posedge clk) disable iff (!nrst)
    (o_vld && head_ok) |-> (o_ovf == head_ovf))
  else
  begin
    $display("MISMATCH %0t: overflow %b, expected %b", $time, $sampled(o_ovf),
             $sampled(head_ovf));
    err_cnt++;
  end

  tag_check: assert property (@(posedge clk) disable iff (!nrst)
    (o_vld && head_ok) |-> (o_tag == head_tag))
  else
  begin
    $display("MISMATCH %0t: tag %h, expected %h", $time, $sampled(o_tag),
             $sampled(head_tag));
    err_cnt++;
  end

  // an operation is in flight exactly while the queue holds it
  busy_check: assert property (@(posedge clk) disable iff (!nrst)
    o_busy == head_ok)
  else
  begin
    $display("MISMATCH %0t: busy %b with %0d operations pending", $time, $sampled(o_busy),
             exp_q.size());
    err_cnt++;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("run timed out after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // small random values keep a*x+b well inside the Q16.16 range
  function automatic vxe_pkg::fix_t small_val();
    logic signed [23:0] v;
    v = 24'($urandom);
    return vxe_pkg::fix_t'(v);
  endfunction

  task automatic send_op(input vxe_pkg::fix_t a, input vxe_pkg::fix_t x,
                         input vxe_pkg::fix_t b, input vxe_pkg::tag_t tag);
    i_vld <= 1'b1;
    i_a   <= a;
    i_x   <= x;
    i_b   <= b;
    i_tag <= tag;
    @(posedge clk);
  endtask

  task automatic send_random();
    send_op(small_val(), small_val(), small_val(), vxe_pkg::tag_t'($urandom));
  endtask

  task automatic idle(input int n);
    i_vld <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  // let the lane empty, then close the test with its line
  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    idle(1);
    while ((head_ok || o_busy) && waited < 40)
    begin
      @(posedge clk);
      waited++;
    end
    if (waited >= 40)
    begin
      $display("%s: lane did not drain, results are missing", name);
      err_cnt++;
    end
    idle(3);
    n_tests++;
    $display("test %0d %s finished, errors so far %0d", n_tests, name,
             err_cnt + dut0.props0.fail_cnt);
  endtask

  initial
  begin
    void'($urandom(21));
    clk   = 1'b0;
    nrst  <= 1'b0;
    i_vld = 1'b0;
    i_a   = '0;
    i_x   = '0;
    i_b   = '0;
    i_tag = '0;
    repeat (5) @(posedge clk);
    nrst <= 1'b1;
    idle(2);

    // 1.5 times -0.75 plus one lsb gives a negative truncated product
    send_op(32'h0001_8000, 32'hffff_4000, 32'h0000_0001, 4'h9);
    finish_test("single");

    for (int i = 0; i < 64; i++)
    begin
      send_random();
    end
    finish_test("streaming");

    // 1.0 times a limit lands exactly on it, one lsb further saturates
    send_op(32'h0001_0000, 32'h7fff_ffff, 32'h0000_0000, 4'h1);
    send_op(32'h0001_0000, 32'h8000_0000, 32'h0000_0000, 4'h2);
    send_op(32'h0001_0000, 32'h7fff_ffff, 32'h0000_0001, 4'h3);
    send_op(32'h0001_0000, 32'h8000_0000, 32'hffff_ffff, 4'h4);
    send_op(32'h7fff_ffff, 32'h7fff_ffff, 32'h0000_0000, 4'h5);
    send_op(32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000, 4'h6);
    finish_test("saturation");

    for (int i = 0; i < 200; i++)
    begin
      send_random();
      idle($urandom_range(0, 6));
      // a longer pause lets busy fall between bursts
      if (i % 40 == 39)
      begin
        idle(12);
      end
    end
    finish_test("gaps");

    for (int i = 0; i < 4; i++)
    begin
      send_random();
    end
    i_vld <= 1'b0;
    nrst  <= 1'b0;
    repeat (3) @(posedge clk);
    nrst <= 1'b1;
    idle(20);
    finish_test("reset in flight");

    // failures of the bound property checks count towards the total
    err_cnt = err_cnt + dut0.props0.fail_cnt;
    $display("tests %0d, errors %0d", n_tests, err_cnt);
    if (err_cnt == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vxe_fma_top.f
rtl/vxe_pkg.sv
rtl/vxe_pipe.sv
rtl/vxe_mul_pipe.sv
rtl/vxe_res_if.sv
rtl/vxe_fma_datapath.sv
rtl/vxe_result_sat.sv
rtl/vxe_fma_top.sv
sim/vxe_fma_props.sv
sim/vxe_fma_tb.sv
